// ==== compile.f ====
hw/mhq_pkg.sv
hw/mhq_entry.sv
hw/mhq_lookup.sv
hw/mhq_queue_ctrl.sv
hw/mhq.sv
tb/mhq_asserts.sv
tb/mhq_tb.sv

// ==== Makefile ====
# Verilator flow for the miss handling queue

VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= mhq_tb
RTL_TOP   ?= mhq
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/mhq_tb.sv ====
/*
 * Miss handling queue testbench
 * Bus model, reference model of the pending lines and response and fill checks
 */

`timescale 1ns/100ps

module mhq_tb;

    import mhq_pkg::*;

    localparam int DEPTH = MHQ_DEPTH;
    localparam int LBYTES = MHQ_LINE_SIZE;

    logic clk = 1'b0;
    logic i_rst_n, i_lookup_valid, i_lookup_dc_hit, i_biu_done;
    logic [31:0] i_lookup_addr, i_lookup_data;
    mem_op_t i_lookup_op;
    logic [127:0] i_biu_data;
    logic [1:0] o_lookup_tag, o_fill_tag;
    logic o_lookup_retry, o_lookup_replay, o_fill_en, o_fill_dirty, o_biu_en;
    logic [31:0] o_fill_addr, o_biu_addr;
    logic [127:0] o_fill_data;

    // Model of the pending lines in allocation order
    logic [31:4] q_line[$];
    logic [15:0] q_mask[$];
    logic [127:0] q_data[$];
    logic q_dirty[$];
    logic [1:0] q_tag[$];
    logic [1:0] next_tag = '0;
    logic [31:4] rp_line;
    int rp_first = -10, rp_last = -10;
    int cycles = 0, errs = 0, test_errs = 0, tests_run = 0, tests_failed = 0;
    int retries = 0, replays = 0, bus_reqs = 0, fills = 0;
    logic bus_hold = 1'b0;
    string cur_test = "reset";

    mhq uut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("Timeout after %0d cycles in test %s", cycles, cur_test);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Every byte of a memory line depends on the full line address
    function automatic logic [127:0] mem_line(logic [31:4] la);
        logic [127:0] line;
        logic [7:0] h;
        h = la[11:4] ^ la[19:12] ^ la[27:20] ^ {4'h0, la[31:28]};
        for (int i = 0; i < LBYTES; i++) begin
            line[i*8 +: 8] = h * 8'd29 + 8'(i) * 8'd37 + la[7:0] + 8'h11;
        end
        return line;
    endfunction

    function automatic logic [127:0] expected_fill(logic [31:4] la, logic [15:0] mask,
                                                   logic [127:0] data);
        logic [127:0] mem;
        logic [127:0] line;
        mem = mem_line(la);
        for (int i = 0; i < LBYTES; i++) begin
            line[i*8 +: 8] = mask[i] ? data[i*8 +: 8] : mem[i*8 +: 8];
        end
        return line;
    endfunction

    function automatic int find_line(logic [31:4] la);
        for (int i = 0; i < q_line.size(); i++) begin
            if (q_line[i] == la) return i;
        end
        return -1;
    endfunction

    task automatic model_write(int idx, logic [31:0] a, mem_op_t op, logic [31:0] d);
        int n;
        int off;
        n = (op == OP_STORE_B) ? 1 : (op == OP_STORE_H) ? 2 : (op == OP_STORE_W) ? 4 : 0;
        off = int'(a[3:0]);
        for (int k = 0; k < n; k++) begin
            q_mask[idx][off+k] = 1'b1;
            q_data[idx][(off+k)*8 +: 8] = d[k*8 +: 8];
        end
        if (n != 0) q_dirty[idx] = 1'b1;
    endtask

    task automatic fail_check(string what, logic [127:0] exp, logic [127:0] act);
        $display("Mismatch in %s: %s expected %0h actual %0h", cur_test, what, exp, act);
        errs++;
        test_errs++;
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        errs++;
        test_errs++;
    endtask

    // A request seen before an edge is judged just after it
    initial begin : compare_responses
        logic [31:0] a;
        logic [31:0] d;
        mem_op_t op;
        int idx;
        int exp_res;
        int act_res;
        logic [1:0] exp_tag;
        forever begin
            @(negedge clk);
            if (i_rst_n && i_lookup_valid && !i_lookup_dc_hit) begin
                a = i_lookup_addr;
                op = i_lookup_op;
                d = i_lookup_data;
                @(posedge clk);
                #1;
                idx = find_line(a[31:4]);
                exp_tag = '0;
                if (a[31:4] == rp_line && cycles >= rp_first && cycles <= rp_last) begin
                    exp_res = 2;
                end else if (idx >= 0) begin
                    exp_res = 0;
                end else if (q_line.size() == DEPTH) begin
                    exp_res = 1;
                end else begin
                    exp_res = 0;
                    q_line.push_back(a[31:4]);
                    q_mask.push_back('0);
                    q_data.push_back('0);
                    q_dirty.push_back(1'b0);
                    q_tag.push_back(next_tag);
                    next_tag++;
                    idx = q_line.size() - 1;
                end
                if (exp_res == 0) begin
                    exp_tag = q_tag[idx];
                    model_write(idx, a, op, d);
                end
                act_res = o_lookup_retry ? (o_lookup_replay ? 3 : 1) : (o_lookup_replay ? 2 : 0);
                assert (act_res == exp_res) else fail_check("response", exp_res, act_res);
                if (exp_res == 0 && act_res == 0) begin
                    assert (o_lookup_tag == exp_tag) else fail_check("tag", exp_tag, o_lookup_tag);
                end
                if (act_res == 1) retries++;
                if (act_res == 2) replays++;
            end
        end
    end

    // Checks each fill and notes when a done pulse opens the replay window
    initial begin : compare_fills
        logic [127:0] exp_line;
        forever begin
            @(negedge clk);
            if (i_rst_n && i_biu_done && q_line.size() > 0) begin
                rp_line = q_line[0];
                rp_first = cycles + 1;
                rp_last = cycles + 3;
            end
            if (i_rst_n && o_fill_en) begin
                fills++;
                assert (q_line.size() > 0) else begin
                    report_failure($sformatf("Fill of line %h in %s with no pending line",
                                             o_fill_addr, cur_test));
                end
                if (q_line.size() > 0) begin
                    exp_line = expected_fill(q_line[0], q_mask[0], q_data[0]);
                    assert (o_fill_tag == q_tag[0])
                        else fail_check("fill tag", q_tag[0], o_fill_tag);
                    assert (o_fill_addr == {q_line[0], 4'h0})
                        else fail_check("fill addr", {q_line[0], 4'h0}, o_fill_addr);
                    assert (o_fill_dirty == q_dirty[0])
                        else fail_check("dirty", q_dirty[0], o_fill_dirty);
                    assert (o_fill_data == exp_line)
                        else fail_check("fill data", exp_line, o_fill_data);
                    void'(q_line.pop_front());
                    void'(q_mask.pop_front());
                    void'(q_data.pop_front());
                    void'(q_dirty.pop_front());
                    void'(q_tag.pop_front());
                end
            end
        end
    end

    // Bus model answers each request after 2 to 10 cycles
    initial begin : bus_model
        logic [31:0] a;
        int delay;
        forever begin
            @(negedge clk);
            if (i_rst_n && o_biu_en && !bus_hold) begin
                a = o_biu_addr;
                bus_reqs++;
                assert (q_line.size() > 0) else begin
                    report_failure($sformatf("Bus request for %h in %s with no pending line",
                                             a, cur_test));
                end
                if (q_line.size() > 0) begin
                    assert (a[31:4] == q_line[0])
                        else fail_check("biu addr", {q_line[0], 4'h0}, a);
                end
                delay = 2 + int'($urandom % 9);
                repeat (delay) @(posedge clk);
                i_biu_done <= 1'b1;
                i_biu_data <= mem_line(a[31:4]);
                @(posedge clk);
                i_biu_done <= 1'b0;
            end
        end
    end

    task automatic drive_req(logic [31:0] a, mem_op_t op, logic [31:0] d);
        @(posedge clk);
        i_lookup_valid <= 1'b1;
        i_lookup_addr <= a;
        i_lookup_op <= op;
        i_lookup_data <= d;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            i_lookup_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(2);
        while (q_line.size() > 0) @(negedge clk);
        idle(6);
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("%s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "failed", test_errs);
        test_errs = 0;
    endtask

    initial begin : stimulus
        int r0;
        int b0;
        int f0;
        mem_op_t op;
        logic [31:0] a;
        void'($urandom(32'ha5fa3cbf));
        i_rst_n = 1'b0;
        i_lookup_valid = 1'b0;
        i_lookup_dc_hit = 1'b0;
        i_lookup_addr = '0;
        i_lookup_op = OP_LOAD;
        i_lookup_data = '0;
        i_biu_done = 1'b0;
        i_biu_data = '0;
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        idle(2);

        cur_test = "load_miss";
        drive_req(32'h0000_1004, OP_LOAD, 32'h0);
        drain();
        end_test();

        cur_test = "store_merge";
        drive_req(32'h0000_2001, OP_STORE_B, 32'h0000_00a7);
        idle(1);
        drive_req(32'h0000_2006, OP_STORE_H, 32'h0000_b3c4);
        drive_req(32'h0000_200c, OP_STORE_W, 32'hdead_beef);
        drive_req(32'h0000_2030, OP_STORE_H, 32'h0000_1234);
        drain();
        end_test();

        cur_test = "same_line";
        b0 = bus_reqs;
        f0 = fills;
        drive_req(32'h0000_3000, OP_LOAD, 32'h0);
        drive_req(32'h0000_3005, OP_STORE_B, 32'h0000_0055);
        drive_req(32'h0000_3008, OP_STORE_W, 32'h0102_0304);
        idle(1);
        drive_req(32'h0000_300e, OP_STORE_H, 32'h0000_7788);
        drain();
        assert (bus_reqs - b0 == 1) else fail_check("bus requests", 1, bus_reqs - b0);
        assert (fills - f0 == 1) else fail_check("fills", 1, fills - f0);
        end_test();

        cur_test = "full_queue";
        r0 = retries;
        bus_hold = 1'b1;
        for (int i = 0; i < DEPTH; i++) drive_req(32'h0000_4000 + i * 16, OP_LOAD, 32'h0);
        drive_req(32'h0000_4100, OP_LOAD, 32'h0);
        drive_req(32'h0000_4014, OP_STORE_W, 32'hcafe_f00d);
        idle(2);
        bus_hold = 1'b0;
        drain();
        assert (retries - r0 == 1) else fail_check("retries", 1, retries - r0);
        end_test();

        cur_test = "replay";
        r0 = replays;
        drive_req(32'h0000_5008, OP_STORE_B, 32'h0000_0099);
        idle(1);
        @(negedge clk);
        while (!i_biu_done) @(negedge clk);
        drive_req(32'h0000_5004, OP_STORE_W, 32'h5555_aaaa);
        drain();
        assert (replays - r0 == 1) else fail_check("replays", 1, replays - r0);
        end_test();

        cur_test = "fill_order";
        for (int n = 0; n < 80; n++) begin
            op = mem_op_t'($urandom % 4);
            a = 32'h0000_6000 + ($urandom % 8) * 16;
            case (op)
                OP_STORE_H: a[3:0] = 4'(($urandom % 8) * 2);
                OP_STORE_W: a[3:0] = 4'(($urandom % 4) * 4);
                default:    a[3:0] = 4'($urandom % 16);
            endcase
            drive_req(a, op, $urandom);
            if ($urandom % 3 == 0) idle(1 + int'($urandom % 3));
        end
        drain();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errs);
        if (errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/mhq_asserts.sv ====
/*
 * Miss handling queue protocol checks
 * Bus request and fill timing rules, bound to the top level
 */

`timescale 1ns/100ps

module mhq_asserts #(
    parameter int  OPTN_ADDR_WIDTH = mhq_pkg::MHQ_ADDR_WIDTH,
    parameter int  OPTN_LINE_SIZE  = mhq_pkg::MHQ_LINE_SIZE,
    localparam int OFFSET_WIDTH    = $clog2(OPTN_LINE_SIZE)
) (
    input logic                       clk,
    input logic                       i_rst_n,
    input logic                       i_biu_done,
    input logic                       o_fill_en,
    input logic                       o_biu_en,
    input logic [OPTN_ADDR_WIDTH-1:0] o_biu_addr
);

    // A done pulse leads to a fill two edges later and never otherwise
    a_fill_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_biu_done |-> ##2 o_fill_en) else $error("fill did not follow the done pulse");

    a_fill_needs_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_fill_en |-> $past(i_biu_done, 2)) else $error("fill without a done pulse");

    a_biu_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_biu_en |-> (o_biu_addr[OFFSET_WIDTH-1:0] == '0))
        else $error("bus address is not line aligned");

    a_biu_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_biu_en && !i_biu_done) |=> $stable(o_biu_addr))
        else $error("bus address changed while the request was pending");

endmodule

bind mhq mhq_asserts #(
    .OPTN_ADDR_WIDTH(OPTN_ADDR_WIDTH),
    .OPTN_LINE_SIZE (OPTN_LINE_SIZE)
) u_asserts (.*);

// ==== hw/mhq.sv ====
/*
 * Miss handling queue top level
 * Entries, lookup pipeline and pointers, with the bus request and
 * the registered fill towards the data cache
 */

`timescale 1ns/100ps

module mhq #(
    parameter int  OPTN_DATA_WIDTH = mhq_pkg::MHQ_DATA_WIDTH,
    parameter int  OPTN_ADDR_WIDTH = mhq_pkg::MHQ_ADDR_WIDTH,
    parameter int  OPTN_MHQ_DEPTH  = mhq_pkg::MHQ_DEPTH,
    parameter int  OPTN_LINE_SIZE  = mhq_pkg::MHQ_LINE_SIZE,
    localparam int IDX_WIDTH       = $clog2(OPTN_MHQ_DEPTH),
    localparam int OFFSET_WIDTH    = $clog2(OPTN_LINE_SIZE),
    localparam int LINE_WIDTH      = OPTN_LINE_SIZE * 8
) (
    input  logic                       clk,
    input  logic                       i_rst_n,

    input  logic                       i_lookup_valid,
    input  logic                       i_lookup_dc_hit,
    input  logic [OPTN_ADDR_WIDTH-1:0] i_lookup_addr,
    input  mhq_pkg::mem_op_t           i_lookup_op,
    input  logic [OPTN_DATA_WIDTH-1:0] i_lookup_data,
    output logic [IDX_WIDTH-1:0]       o_lookup_tag,
    output logic                       o_lookup_retry,
    output logic                       o_lookup_replay,

    output logic                       o_fill_en,
    output logic [IDX_WIDTH-1:0]       o_fill_tag,
    output logic                       o_fill_dirty,
    output logic [OPTN_ADDR_WIDTH-1:0] o_fill_addr,
    output logic [LINE_WIDTH-1:0]      o_fill_data,

    input  logic                       i_biu_done,
    input  logic [LINE_WIDTH-1:0]      i_biu_data,
    output logic                       o_biu_en,
    output logic [OPTN_ADDR_WIDTH-1:0] o_biu_addr
);

    logic [IDX_WIDTH-1:0]                 head;
    logic [IDX_WIDTH-1:0]                 tail;
    logic                                 queue_full;
    logic                                 queue_empty;
    logic                                 allocating;

    logic [OPTN_MHQ_DEPTH-1:0]            entry_valid;
    logic [OPTN_MHQ_DEPTH-1:0]            entry_complete;
    logic [OPTN_MHQ_DEPTH-1:0]            entry_dirty;
    logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] entry_addr [OPTN_MHQ_DEPTH];
    logic [LINE_WIDTH-1:0]                entry_data [OPTN_MHQ_DEPTH];
    logic [OPTN_MHQ_DEPTH-1:0]            entry_hit_select;
    logic [OPTN_MHQ_DEPTH-1:0]            alloc_select;

    logic [OPTN_MHQ_DEPTH-1:0]            update_select;
    logic                                 update_we;
    logic [LINE_WIDTH-1:0]                update_wr_data;
    logic [OPTN_LINE_SIZE-1:0]            update_byte_select;
    logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] update_addr;

    logic [OPTN_MHQ_DEPTH-1:0]            biu_done;
    logic [OPTN_MHQ_DEPTH-1:0]            fill_launched;
    logic                                 head_complete;
    logic                                 lookup_completing;
    logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] fill_addr_r;

    assign head_complete = entry_complete[head];

    // Done is aimed at the head only; a complete head launches its fill on the next edge
    always_comb begin
        biu_done            = '0;
        biu_done[head]      = i_biu_done;
        fill_launched       = '0;
        fill_launched[head] = head_complete;
        alloc_select        = '0;
        alloc_select[tail]  = 1'b1;
    end

    // The head line counts as completing from the done cycle on, so a late merge
    // can never miss the fill
    assign lookup_completing = head_complete | i_biu_done;

    for (genvar g = 0; g < OPTN_MHQ_DEPTH; g++) begin : gen_entry
        mhq_entry #(
            .OPTN_ADDR_WIDTH(OPTN_ADDR_WIDTH),
            .OPTN_LINE_SIZE (OPTN_LINE_SIZE)
        ) u_entry (
            .clk                 (clk),
            .i_rst_n             (i_rst_n),
            .i_lookup_addr       (i_lookup_addr[OPTN_ADDR_WIDTH-1:OFFSET_WIDTH]),
            .o_lookup_hit        (entry_hit_select[g]),
            .i_update_en         (update_select[g]),
            .i_update_we         (update_we),
            .i_update_wr_data    (update_wr_data),
            .i_update_byte_select(update_byte_select),
            .i_update_addr       (update_addr),
            .i_biu_done          (biu_done[g]),
            .i_biu_data          (i_biu_data),
            .i_fill_launched     (fill_launched[g]),
            .o_entry_valid       (entry_valid[g]),
            .o_entry_complete    (entry_complete[g]),
            .o_entry_dirty       (entry_dirty[g]),
            .o_entry_addr        (entry_addr[g]),
            .o_entry_data        (entry_data[g])
        );
    end

    mhq_lookup #(
        .OPTN_DATA_WIDTH(OPTN_DATA_WIDTH),
        .OPTN_ADDR_WIDTH(OPTN_ADDR_WIDTH),
        .OPTN_MHQ_DEPTH (OPTN_MHQ_DEPTH),
        .OPTN_LINE_SIZE (OPTN_LINE_SIZE)
    ) u_lookup (
        .clk                 (clk),
        .i_rst_n             (i_rst_n),
        .i_lookup_valid      (i_lookup_valid),
        .i_lookup_dc_hit     (i_lookup_dc_hit),
        .i_lookup_addr       (i_lookup_addr),
        .i_lookup_op         (i_lookup_op),
        .i_lookup_data       (i_lookup_data),
        .i_entry_hit_select  (entry_hit_select),
        .i_alloc_select      (alloc_select),
        .i_full              (queue_full),
        .i_completing        (lookup_completing),
        .i_completing_addr   (entry_addr[head]),
        .i_filling           (o_fill_en),
        .i_filling_addr      (fill_addr_r),
        .o_lookup_tag        (o_lookup_tag),
        .o_lookup_retry      (o_lookup_retry),
        .o_lookup_replay     (o_lookup_replay),
        .o_allocating        (allocating),
        .o_update_select     (update_select),
        .o_update_we         (update_we),
        .o_update_wr_data    (update_wr_data),
        .o_update_byte_select(update_byte_select),
        .o_update_addr       (update_addr)
    );

    mhq_queue_ctrl #(
        .OPTN_MHQ_DEPTH(OPTN_MHQ_DEPTH)
    ) u_queue_ctrl (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_incr_head(head_complete),
        .i_incr_tail(allocating),
        .o_head     (head),
        .o_tail     (tail),
        .o_full     (queue_full),
        .o_empty    (queue_empty)
    );

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_fill_en <= 1'b0;
        end else begin
            o_fill_en <= head_complete;
        end
    end

    always_ff @(posedge clk) begin
        o_fill_tag   <= head;
        o_fill_dirty <= entry_dirty[head];
        fill_addr_r  <= entry_addr[head];
        o_fill_data  <= entry_data[head];
    end

    assign o_fill_addr = {fill_addr_r, {OFFSET_WIDTH{1'b0}}};

    // The tail moves a cycle before the entry turns valid, so check both
    assign o_biu_en   = ~queue_empty & entry_valid[head] & ~head_complete;
    assign o_biu_addr = {entry_addr[head], {OFFSET_WIDTH{1'b0}}};

endmodule

// ==== hw/mhq_queue_ctrl.sv ====
/*
 * Miss handling queue pointers
 * Circular head and tail with a wrap bit for full and empty
 */

`timescale 1ns/100ps

module mhq_queue_ctrl #(
    parameter int  OPTN_MHQ_DEPTH = mhq_pkg::MHQ_DEPTH,
    localparam int IDX_WIDTH      = $clog2(OPTN_MHQ_DEPTH)
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_incr_head,
    input  logic                 i_incr_tail,
    output logic [IDX_WIDTH-1:0] o_head,
    output logic [IDX_WIDTH-1:0] o_tail,
    output logic                 o_full,
    output logic                 o_empty
);

    // Top bit flips on every wrap of the index bits
    logic [IDX_WIDTH:0] head_ptr;
    logic [IDX_WIDTH:0] tail_ptr;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + (IDX_WIDTH+1)'(i_incr_head);
            tail_ptr <= tail_ptr + (IDX_WIDTH+1)'(i_incr_tail);
        end
    end

    assign o_head  = head_ptr[IDX_WIDTH-1:0];
    assign o_tail  = tail_ptr[IDX_WIDTH-1:0];
    assign o_empty = (head_ptr == tail_ptr);

    // Same slot but different lap means every entry is taken
    assign o_full  = (head_ptr[IDX_WIDTH-1:0] == tail_ptr[IDX_WIDTH-1:0]) &
                     (head_ptr[IDX_WIDTH] != tail_ptr[IDX_WIDTH]);

endmodule

// ==== hw/mhq_lookup.sv ====
/*
 * Miss handling queue lookup and update stages
 * Resolves hit, allocate, retry and replay for each request and
 * registers the line write that the entries apply one cycle later
 */

`timescale 1ns/100ps

module mhq_lookup #(
    parameter int  OPTN_DATA_WIDTH = mhq_pkg::MHQ_DATA_WIDTH,
    parameter int  OPTN_ADDR_WIDTH = mhq_pkg::MHQ_ADDR_WIDTH,
    parameter int  OPTN_MHQ_DEPTH  = mhq_pkg::MHQ_DEPTH,
    parameter int  OPTN_LINE_SIZE  = mhq_pkg::MHQ_LINE_SIZE,
    localparam int IDX_WIDTH       = $clog2(OPTN_MHQ_DEPTH),
    localparam int OFFSET_WIDTH    = $clog2(OPTN_LINE_SIZE),
    localparam int LINE_WIDTH      = OPTN_LINE_SIZE * 8
) (
    input  logic                                 clk,
    input  logic                                 i_rst_n,

    input  logic                                 i_lookup_valid,
    input  logic                                 i_lookup_dc_hit,
    input  logic [OPTN_ADDR_WIDTH-1:0]           i_lookup_addr,
    input  mhq_pkg::mem_op_t                     i_lookup_op,
    input  logic [OPTN_DATA_WIDTH-1:0]           i_lookup_data,

    input  logic [OPTN_MHQ_DEPTH-1:0]            i_entry_hit_select,
    input  logic [OPTN_MHQ_DEPTH-1:0]            i_alloc_select,
    input  logic                                 i_full,
    input  logic                                 i_completing,
    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_completing_addr,
    input  logic                                 i_filling,
    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_filling_addr,

    output logic [IDX_WIDTH-1:0]                 o_lookup_tag,
    output logic                                 o_lookup_retry,
    output logic                                 o_lookup_replay,
    output logic                                 o_allocating,

    output logic [OPTN_MHQ_DEPTH-1:0]            o_update_select,
    output logic                                 o_update_we,
    output logic [LINE_WIDTH-1:0]                o_update_wr_data,
    output logic [OPTN_LINE_SIZE-1:0]            o_update_byte_select,
    output logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] o_update_addr
);

    import mhq_pkg::*;

    localparam int DATA_BYTES = OPTN_DATA_WIDTH / 8;

    logic                                 lookup_req;
    logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] lookup_line;
    logic [OFFSET_WIDTH-1:0]              lookup_offset;
    logic                                 bypass_hit;
    logic [OPTN_MHQ_DEPTH-1:0]            hit_select;
    logic                                 lookup_hit;
    logic                                 lookup_replay;
    logic                                 lookup_retry;
    logic                                 lookup_record;
    logic [OPTN_MHQ_DEPTH-1:0]            lookup_select;
    logic [IDX_WIDTH-1:0]                 lookup_tag;
    logic                                 store_we;
    logic [DATA_BYTES-1:0]                size_mask;

    assign lookup_req    = i_lookup_valid & ~i_lookup_dc_hit;
    assign lookup_line   = i_lookup_addr[OPTN_ADDR_WIDTH-1:OFFSET_WIDTH];
    assign lookup_offset = i_lookup_addr[OFFSET_WIDTH-1:0];

    // The entry written by the update stage is not valid in the CAM yet, so compare
    // against the update register as well
    assign bypass_hit = (|o_update_select) & (o_update_addr == lookup_line);
    assign hit_select = bypass_hit ? o_update_select : i_entry_hit_select;
    assign lookup_hit = |hit_select;

    // A line already on its way to the cache must not be recorded again
    assign lookup_replay = lookup_req &
                           ((i_completing & (i_completing_addr == lookup_line)) |
                            (i_filling & (i_filling_addr == lookup_line)));
    assign lookup_retry  = lookup_req & ~lookup_replay & ~lookup_hit & i_full;
    assign lookup_record = lookup_req & ~lookup_replay & ~lookup_retry;
    assign o_allocating  = lookup_record & ~lookup_hit;

    assign lookup_select = lookup_record ? (lookup_hit ? hit_select : i_alloc_select) : '0;

    always_comb begin
        lookup_tag = '0;
        for (int i = 0; i < OPTN_MHQ_DEPTH; i++) begin
            if (lookup_select[i]) begin
                lookup_tag = lookup_tag | IDX_WIDTH'(i);
            end
        end
    end

    // Stores are assumed naturally aligned within the line
    always_comb begin
        case (i_lookup_op)
            OP_STORE_B: size_mask = DATA_BYTES'(1);
            OP_STORE_H: size_mask = DATA_BYTES'(3);
            OP_STORE_W: size_mask = '1;
            default:    size_mask = '0;
        endcase
    end

    assign store_we = (i_lookup_op != OP_LOAD);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_lookup_retry  <= 1'b0;
            o_lookup_replay <= 1'b0;
            o_update_select <= '0;
            o_update_we     <= 1'b0;
        end else begin
            o_lookup_retry  <= lookup_retry;
            o_lookup_replay <= lookup_replay;
            o_update_select <= lookup_select;
            o_update_we     <= lookup_record & store_we;
        end
    end

    always_ff @(posedge clk) begin
        o_lookup_tag         <= lookup_tag;
        o_update_addr        <= lookup_line;
        o_update_byte_select <= OPTN_LINE_SIZE'(size_mask) << lookup_offset;
        o_update_wr_data     <= LINE_WIDTH'(i_lookup_data) << {lookup_offset, 3'b000};
    end

endmodule

// ==== hw/mhq_entry.sv ====
/*
 * Miss handling queue entry
 * Holds one missed line with its status, compares it against the lookup address
 * and merges memory data under the bytes already written by stores
 */

`timescale 1ns/100ps

module mhq_entry #(
    parameter int  OPTN_ADDR_WIDTH = mhq_pkg::MHQ_ADDR_WIDTH,
    parameter int  OPTN_LINE_SIZE  = mhq_pkg::MHQ_LINE_SIZE,
    localparam int OFFSET_WIDTH    = $clog2(OPTN_LINE_SIZE),
    localparam int LINE_WIDTH      = OPTN_LINE_SIZE * 8
) (
    input  logic                                 clk,
    input  logic                                 i_rst_n,

    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_lookup_addr,
    output logic                                 o_lookup_hit,

    input  logic                                 i_update_en,
    input  logic                                 i_update_we,
    input  logic [LINE_WIDTH-1:0]                i_update_wr_data,
    input  logic [OPTN_LINE_SIZE-1:0]            i_update_byte_select,
    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_update_addr,

    input  logic                                 i_biu_done,
    input  logic [LINE_WIDTH-1:0]                i_biu_data,
    input  logic                                 i_fill_launched,

    output logic                                 o_entry_valid,
    output logic                                 o_entry_complete,
    output logic                                 o_entry_dirty,
    output logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] o_entry_addr,
    output logic [LINE_WIDTH-1:0]                o_entry_data
);

    logic                                 entry_valid;
    logic                                 entry_complete;
    logic                                 entry_dirty;
    logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] entry_addr;
    logic [LINE_WIDTH-1:0]                entry_data;
    logic [OPTN_LINE_SIZE-1:0]            entry_written;
    logic                                 allocate;
    logic [OPTN_LINE_SIZE-1:0]            store_mask;

    // An update to a free entry claims it, otherwise it merges
    assign allocate   = i_update_en & ~entry_valid;
    assign store_mask = i_update_byte_select & {OPTN_LINE_SIZE{i_update_en & i_update_we}};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            entry_valid    <= 1'b0;
            entry_complete <= 1'b0;
            entry_dirty    <= 1'b0;
        end else if (i_fill_launched) begin
            entry_valid    <= 1'b0;
            entry_complete <= 1'b0;
        end else if (allocate) begin
            entry_valid    <= 1'b1;
            entry_complete <= 1'b0;
            entry_dirty    <= i_update_we;
        end else begin
            entry_complete <= entry_complete | i_biu_done;
            entry_dirty    <= entry_dirty | (i_update_en & i_update_we);
        end
    end

    // Written-byte mask starts over on allocation
    always_ff @(posedge clk) begin
        if (allocate) begin
            entry_addr    <= i_update_addr;
            entry_written <= store_mask;
        end else if (i_update_en) begin
            entry_written <= entry_written | store_mask;
        end
    end

    // Store bytes win over memory data, even when both land on the same edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < OPTN_LINE_SIZE; i++) begin
            if (store_mask[i]) begin
                entry_data[i*8 +: 8] <= i_update_wr_data[i*8 +: 8];
            end else if (i_biu_done && !entry_written[i]) begin
                entry_data[i*8 +: 8] <= i_biu_data[i*8 +: 8];
            end
        end
    end

    assign o_lookup_hit     = entry_valid & (entry_addr == i_lookup_addr);
    assign o_entry_valid    = entry_valid;
    assign o_entry_complete = entry_complete;
    assign o_entry_dirty    = entry_dirty;
    assign o_entry_addr     = entry_addr;
    assign o_entry_data     = entry_data;

endmodule

// ==== hw/mhq_pkg.sv ====
/*
 * Miss handling queue shared definitions
 * Request operation encoding and default sizes
 */

package mhq_pkg;

    // Store ops carry their size, loads never write the line buffer
    typedef enum logic [1:0] {
        OP_LOAD    = 2'b00,
        OP_STORE_B = 2'b01,
        OP_STORE_H = 2'b10,
        OP_STORE_W = 2'b11
    } mem_op_t;

    parameter int MHQ_DATA_WIDTH = 32;
    parameter int MHQ_ADDR_WIDTH = 32;

    // Depth must stay a power of two for the pointer wrap
    parameter int MHQ_DEPTH      = 4;

    // Line size in bytes
    parameter int MHQ_LINE_SIZE  = 16;

endpackage
